// ==== mist_pkg.sv ====
package mist_pkg;

    // ROM buffer geometry
    localparam int ROM_AW   = 8;
    localparam int IOCTL_AW = ROM_AW + 1;

    // io controller commands on SS2
    localparam logic [7:0] CMD_FILE_TX     = 8'h53;
    localparam logic [7:0] CMD_FILE_TX_DAT = 8'h54;

    // video timing, in pixels and lines
    localparam int PXL_DIV      = 2;
    localparam int H_VISIBLE    = 16;
    localparam int H_TOTAL      = 32;
    localparam int H_SYNC_START = 20;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_VISIBLE    = 16;
    localparam int V_TOTAL      = 20;
    localparam int V_SYNC_START = 17;
    localparam int V_SYNC_LEN   = 2;

    // counter widths derived from the timing above
    localparam int DIV_W  = $clog2(PXL_DIV);
    localparam int HCNT_W = $clog2(H_TOTAL);
    localparam int VCNT_W = $clog2(V_TOTAL);

    typedef struct packed {
        logic [IOCTL_AW-1:0] addr;
        logic [7:0]          data;
        logic                wr;
    } ioctl_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic [15:0]       data;
        logic              we;
    } mem_wr_t;

endpackage

// ==== spi_byte_rx.sv ====
module spi_byte_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_sck,
    input  logic       spi_ss2,
    input  logic       spi_di,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_start,
    output logic       frame_end
);

    // two sync stages plus one history stage for edge detection
    logic [2:0] sck_sync;
    logic [2:0] ss2_sync;
    logic [1:0] di_sync;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       sck_rise;
    logic       ss2_fall;
    logic       ss2_rise;

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync <= 3'b000;
            ss2_sync <= 3'b111;
            di_sync  <= 2'b00;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck};
            ss2_sync <= {ss2_sync[1:0], spi_ss2};
            di_sync  <= {di_sync[0], spi_di};
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_sync[2] & ~ss2_sync[1];
    assign ss2_fall = ~ss2_sync[1] & ss2_sync[2];
    assign ss2_rise = ss2_sync[1] & ~ss2_sync[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_start <= ss2_fall;
            frame_end   <= ss2_rise;
            if (ss2_fall) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                // eighth bit completes the byte
                if (bit_cnt == 3'd7) begin
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    // MSB first, stable until the next SCK rise
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shift <= {shift[6:0], di_sync[1]};
        end
    end

    assign byte_data = shift;

endmodule

// ==== data_io.sv ====
module data_io
    import mist_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       frame_start,
    input  logic       frame_end,
    output logic       downloading,
    output ioctl_t     ioctl
);

    logic                cmd_phase;
    logic [7:0]          cmd;
    logic [IOCTL_AW-1:0] addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_phase   <= 1'b1;
            cmd         <= 8'h00;
            addr        <= '0;
            downloading <= 1'b0;
            ioctl       <= '0;
        end else begin
            ioctl.wr <= 1'b0;
            if (frame_start) begin
                // first byte of a new SS2 frame is the command
                cmd_phase <= 1'b1;
            end else if (frame_end) begin
                cmd <= 8'h00;
            end else if (byte_valid) begin
                cmd_phase <= 1'b0;
                if (cmd_phase) begin
                    cmd <= byte_data;
                end else begin
                    case (cmd)
                        CMD_FILE_TX: begin
                            downloading <= |byte_data;
                            if (|byte_data) begin
                                addr <= '0;
                            end
                        end
                        CMD_FILE_TX_DAT: begin
                            // data outside a download is dropped
                            if (downloading) begin
                                ioctl.addr <= addr;
                                ioctl.data <= byte_data;
                                ioctl.wr   <= 1'b1;
                                addr       <= addr + 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== rom_writer.sv ====
module rom_writer
    import mist_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    downloading,
    input  ioctl_t  ioctl,
    output mem_wr_t mem_wr,
    output logic    busy
);

    logic [7:0]        low_byte;
    logic [ROM_AW-1:0] low_addr;
    logic              pending;
    logic              dl_q;
    logic              dl_fall;

    assign dl_fall = dl_q & ~downloading;

    always_ff @(posedge clk) begin
        if (reset) begin
            dl_q      <= 1'b0;
            pending   <= 1'b0;
            mem_wr.we <= 1'b0;
        end else begin
            dl_q      <= downloading;
            mem_wr.we <= 1'b0;
            if (ioctl.wr) begin
                if (!ioctl.addr[0]) begin
                    // even byte waits for its high half
                    low_byte <= ioctl.data;
                    low_addr <= ioctl.addr[IOCTL_AW-1:1];
                    pending  <= 1'b1;
                end else begin
                    mem_wr.addr <= ioctl.addr[IOCTL_AW-1:1];
                    mem_wr.data <= {ioctl.data, low_byte};
                    mem_wr.we   <= 1'b1;
                    pending     <= 1'b0;
                end
            end else if (dl_fall && pending) begin
                // odd length image, flush with a zero high byte
                mem_wr.addr <= low_addr;
                mem_wr.data <= {8'h00, low_byte};
                mem_wr.we   <= 1'b1;
                pending     <= 1'b0;
            end
        end
    end

    // busy outlasts downloading until the flush write is done
    assign busy = downloading | dl_q | mem_wr.we;

endmodule

// ==== rom_buffer.sv ====
module rom_buffer
    import mist_pkg::*;
(
    input  logic              clk,
    input  mem_wr_t           mem_wr,
    input  logic [ROM_AW-1:0] rd_addr,
    output logic [15:0]       rd_data
);

    logic [15:0] mem [0:(1<<ROM_AW)-1];

    always_ff @(posedge clk) begin
        if (mem_wr.we) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== video_timing.sv ====
module video_timing
    import mist_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              busy,
    input  logic [15:0]       rd_data,
    output logic [ROM_AW-1:0] rd_addr,
    output logic              pxl_cen,
    output logic              hs,
    output logic              vs,
    output rgb_t              rgb,
    output logic [31:0]       frame_cnt
);

    logic [DIV_W-1:0]  div_cnt;
    logic [HCNT_W-1:0] h_cnt;
    logic [VCNT_W-1:0] v_cnt;
    logic              visible;
    logic              hs_next;
    logic              vs_next;
    rgb_t              rgb_q;

    assign visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
    assign hs_next = !(h_cnt >= H_SYNC_START && h_cnt < H_SYNC_START + H_SYNC_LEN);
    assign vs_next = !(v_cnt >= V_SYNC_START && v_cnt < V_SYNC_START + V_SYNC_LEN);

    // word for the current position, back before the next pxl_cen
    assign rd_addr = ROM_AW'(v_cnt * H_VISIBLE + h_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            pxl_cen   <= 1'b0;
            h_cnt     <= '0;
            v_cnt     <= '0;
            hs        <= 1'b1;
            vs        <= 1'b1;
            rgb_q     <= '0;
            frame_cnt <= '0;
        end else begin
            div_cnt <= (div_cnt == DIV_W'(PXL_DIV - 1)) ? '0 : div_cnt + 1'b1;
            pxl_cen <= (div_cnt == DIV_W'(PXL_DIV - 1));
            if (pxl_cen) begin
                if (h_cnt == HCNT_W'(H_TOTAL - 1)) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == VCNT_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
                hs <= hs_next;
                vs <= vs_next;
                if (vs && !vs_next) begin
                    frame_cnt <= frame_cnt + 32'd1;
                end
                // 12-bit colour from the low bits of the word
                rgb_q <= visible ? rgb_t'(rd_data[11:0]) : '0;
            end
        end
    end

    assign rgb = busy ? '0 : rgb_q;

endmodule

// ==== mist_core_top.sv ====
module mist_core_top
    import mist_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        spi_sck,
    input  logic        spi_ss2,
    input  logic        spi_di,
    output logic        led,
    output logic        downloading,
    output logic        pxl_cen,
    output logic        hs,
    output logic        vs,
    output rgb_t        rgb,
    output logic [31:0] frame_cnt
);

    logic              byte_valid;
    logic [7:0]        byte_data;
    logic              frame_start;
    logic              frame_end;
    ioctl_t            ioctl;
    mem_wr_t           mem_wr;
    logic              busy;
    logic [ROM_AW-1:0] rd_addr;
    logic [15:0]       rd_data;

    spi_byte_rx u_spi (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .byte_valid  ( byte_valid  ),
        .byte_data   ( byte_data   ),
        .frame_start ( frame_start ),
        .frame_end   ( frame_end   )
    );

    data_io u_data_io (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .byte_valid  ( byte_valid  ),
        .byte_data   ( byte_data   ),
        .frame_start ( frame_start ),
        .frame_end   ( frame_end   ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       )
    );

    rom_writer u_writer (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl       ( ioctl       ),
        .mem_wr      ( mem_wr      ),
        .busy        ( busy        )
    );

    rom_buffer u_rom (
        .clk     ( clk     ),
        .mem_wr  ( mem_wr  ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data )
    );

    video_timing u_video (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .busy      ( busy      ),
        .rd_data   ( rd_data   ),
        .rd_addr   ( rd_addr   ),
        .pxl_cen   ( pxl_cen   ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .rgb       ( rgb       ),
        .frame_cnt ( frame_cnt )
    );

    // LED stays low while the ROM is being loaded
    assign led = ~busy;

endmodule

// ==== mist_core_assert.sv ====
module mist_core_assert
    import mist_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        led,
    input logic        downloading,
    input logic        pxl_cen,
    input logic        hs,
    input logic        vs,
    input rgb_t        rgb,
    input logic [31:0] frame_cnt
);

    localparam int HS_CLKS    = H_SYNC_LEN * PXL_DIV;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * PXL_DIV;
    localparam int LAST_WORD  = (1 << ROM_AW) - 1;

    int                error_count = 0;
    logic [HCNT_W-1:0] x_pos;
    logic [VCNT_W-1:0] y_pos;
    logic              vs_q;
    logic              dl_q;
    logic              dl_done;
    logic              armed;
    logic              frame_seen;
    logic [15:0]       frame_clks;
    logic              in_view;

    // word k holds (k mod 16) in the high byte and 2k in the low byte
    function automatic rgb_t expected_rgb(input int x, input int y);
        int   word;
        rgb_t exp_rgb;
        word = y * H_VISIBLE + x;
        // last word only got its low byte, the flush wrote a zero high half
        exp_rgb.red = (word == LAST_WORD) ? 4'h0 : 4'(word % 16);
        {exp_rgb.green, exp_rgb.blue} = 8'((2 * word) % 256);
        return exp_rgb;
    endfunction

    // pixel position that the registered outputs currently describe
    always_ff @(posedge clk) begin
        if (reset) begin
            x_pos      <= HCNT_W'(H_TOTAL - 1);
            y_pos      <= VCNT_W'(V_TOTAL - 1);
            vs_q       <= 1'b1;
            dl_q       <= 1'b0;
            dl_done    <= 1'b0;
            armed      <= 1'b0;
            frame_seen <= 1'b0;
            frame_clks <= '0;
        end else begin
            vs_q <= vs;
            dl_q <= downloading;
            if (pxl_cen) begin
                if (x_pos == HCNT_W'(H_TOTAL - 1)) begin
                    x_pos <= '0;
                    y_pos <= (y_pos == VCNT_W'(V_TOTAL - 1)) ? '0 : y_pos + 1'b1;
                end else begin
                    x_pos <= x_pos + 1'b1;
                end
            end
            if (dl_q && !downloading) begin
                dl_done <= 1'b1;
            end
            if (vs_q && !vs) begin
                frame_seen <= 1'b1;
                frame_clks <= 16'd1;
                // a whole frame rescans the buffer once the load is over
                if (dl_done && led) begin
                    armed <= 1'b1;
                end
            end else begin
                frame_clks <= frame_clks + 16'd1;
            end
        end
    end

    assign in_view = (x_pos < H_VISIBLE) && (y_pos < V_VISIBLE);

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> led && hs && vs && !downloading && frame_cnt == 32'd0)
        else begin error_count++; $error("outputs wrong after reset"); end

    pixel_enable: assert property (@(posedge clk) disable iff (reset)
        pxl_cen |=> (!pxl_cen)[*PXL_DIV-1] ##1 pxl_cen)
        else begin error_count++; $error("pxl_cen period wrong"); end

    blank_outside: assert property (@(posedge clk) disable iff (reset)
        !in_view |-> rgb == '0)
        else begin error_count++; $error("rgb not blank at x=%0d y=%0d", x_pos, y_pos); end

    blank_busy: assert property (@(posedge clk) disable iff (reset)
        !led |-> rgb == '0)
        else begin error_count++; $error("rgb not blank while led is low"); end

    led_in_download: assert property (@(posedge clk) disable iff (reset)
        downloading |-> !led)
        else begin error_count++; $error("led high during download"); end

    led_after_download: assert property (@(posedge clk) disable iff (reset)
        $fell(downloading) |-> ##[1:2] led)
        else begin error_count++; $error("led not back high after download"); end

    hs_position: assert property (@(posedge clk) disable iff (reset)
        $fell(hs) |-> x_pos == H_SYNC_START)
        else begin error_count++; $error("hs fell at x=%0d", x_pos); end

    hs_width: assert property (@(posedge clk) disable iff (reset)
        $fell(hs) |=> (!hs)[*HS_CLKS-1] ##1 hs)
        else begin error_count++; $error("hs low width wrong"); end

    vs_position: assert property (@(posedge clk) disable iff (reset)
        $fell(vs) |-> y_pos == V_SYNC_START && x_pos == 0)
        else begin error_count++; $error("vs fell at x=%0d y=%0d", x_pos, y_pos); end

    frame_length: assert property (@(posedge clk) disable iff (reset)
        ($fell(vs) && frame_seen) |-> frame_clks == FRAME_CLKS)
        else begin error_count++; $error("frame took %0d clk", frame_clks); end

    frame_count_step: assert property (@(posedge clk) disable iff (reset)
        $fell(vs) |-> frame_cnt == $past(frame_cnt) + 32'd1)
        else begin error_count++; $error("frame_cnt did not step at vs"); end

    frame_count_hold: assert property (@(posedge clk) disable iff (reset)
        !$fell(vs) |-> $stable(frame_cnt))
        else begin error_count++; $error("frame_cnt changed outside vs"); end

    content: assert property (@(posedge clk) disable iff (reset)
        (armed && led && in_view) |-> rgb == expected_rgb(x_pos, y_pos))
        else begin
            error_count++;
            $error("rgb %h at x=%0d y=%0d, expected %h", rgb, x_pos, y_pos,
                   expected_rgb(x_pos, y_pos));
        end

endmodule

bind mist_core_top mist_core_assert mist_core_assert_inst (.*);

// ==== mist_core_tb.sv ====
module mist_core_tb
    import mist_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_SKEW = 10;
    localparam int SCK_PHASE  = 4;
    localparam int ROM_BYTES  = 2 * (1 << ROM_AW) - 1;
    // two start bytes, two end bytes and the data command
    localparam int BYTE_COUNT = ROM_BYTES + 5;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * PXL_DIV;
    localparam int WATCHDOG_CLKS = BYTE_COUNT * 80 + 5 * FRAME_CLKS;

    logic        clk;
    logic        reset;
    logic        spi_sck;
    logic        spi_ss2;
    logic        spi_di;
    logic        led;
    logic        downloading;
    logic        pxl_cen;
    logic        hs;
    logic        vs;
    rgb_t        rgb;
    logic [31:0] frame_cnt;
    integer      seed = 32'h6035;

    mist_core_top mist_core_top_inst (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .spi_sck     ( spi_sck     ),
        .spi_ss2     ( spi_ss2     ),
        .spi_di      ( spi_di      ),
        .led         ( led         ),
        .downloading ( downloading ),
        .pxl_cen     ( pxl_cen     ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .rgb         ( rgb         ),
        .frame_cnt   ( frame_cnt   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // inputs change a little after the rising edge
    task automatic hold_clks(input int count);
        if (count > 0) begin
            repeat (count) @(posedge clk);
            #(DRIVE_SKEW);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int b = 7; b >= 0; b--) begin
            spi_di  = value[b];
            spi_sck = 1'b0;
            hold_clks(SCK_PHASE);
            spi_sck = 1'b1;
            hold_clks(SCK_PHASE);
        end
    endtask

    task automatic idle_sck(input int periods);
        spi_sck = 1'b0;
        hold_clks(periods * 2 * SCK_PHASE);
    endtask

    task automatic begin_frame();
        spi_sck = 1'b0;
        spi_ss2 = 1'b0;
        hold_clks(SCK_PHASE);
    endtask

    task automatic end_frame();
        spi_sck = 1'b0;
        hold_clks(SCK_PHASE);
        spi_ss2 = 1'b1;
        hold_clks(2 * SCK_PHASE);
    endtask

    task automatic send_file_tx(input logic [7:0] arg);
        begin_frame();
        send_byte(CMD_FILE_TX);
        send_byte(arg);
        end_frame();
    endtask

    // high byte of word k is k mod 16 and every other byte is its index
    function automatic logic [7:0] rom_byte(input int index);
        if (index % 2 == 1) begin
            return 8'((index / 2) % 16);
        end else begin
            return 8'(index % 256);
        end
    endfunction

    task automatic send_rom_image();
        int gap;
        begin_frame();
        send_byte(CMD_FILE_TX_DAT);
        for (int i = 0; i < ROM_BYTES; i++) begin
            send_byte(rom_byte(i));
            gap = $random(seed) & 3;
            idle_sck(gap);
        end
        end_frame();
    endtask

    task automatic wait_frames(input int count);
        logic [31:0] target;
        target = frame_cnt + count;
        while (frame_cnt != target) begin
            hold_clks(1);
        end
    endtask

    task automatic wait_download(input logic level, input string reason);
        int n;
        n = 0;
        while (downloading !== level && n < 40) begin
            hold_clks(1);
            n++;
        end
        if (downloading !== level) begin
            abort_run(reason);
        end
    endtask

    always @(negedge clk) begin
        if (mist_core_top_inst.mist_core_assert_inst.error_count != 0) begin
            abort_run("an assertion on the DUT outputs failed");
        end
    end

    initial begin
        #(WATCHDOG_CLKS * CLK_PERIOD);
        abort_run("watchdog expired before the download and frames finished");
    end

    initial begin
        reset   = 1'b1;
        spi_sck = 1'b0;
        spi_ss2 = 1'b1;
        spi_di  = 1'b0;
        repeat (2) @(posedge clk);
        #(DRIVE_SKEW);
        reset = 1'b0;

        // one frame from the empty buffer
        wait_frames(1);
        send_file_tx(8'hff);
        wait_download(1'b1, "downloading did not rise after the start command");
        send_rom_image();
        send_file_tx(8'h00);
        wait_download(1'b0, "downloading did not fall after the end command");

        hold_clks(3);
        if (led !== 1'b1) begin
            $display("** Error at time %0t: led expected %b, got %b", $time, 1'b1, led);
            abort_run("led did not return high after the download");
        end

        wait_frames(3);
        if (mist_core_top_inst.mist_core_assert_inst.error_count != 0) begin
            abort_run("an assertion on the DUT outputs failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== mist_core_top.f ====
mist_pkg.sv
spi_byte_rx.sv
data_io.sv
rom_writer.sv
rom_buffer.sv
video_timing.sv
mist_core_top.sv
mist_core_assert.sv
mist_core_tb.sv

// ==== Bender.yml ====
package:
  name: mist_core

sources:
  - mist_pkg.sv
  - spi_byte_rx.sv
  - data_io.sv
  - rom_writer.sv
  - rom_buffer.sv
  - video_timing.sv
  - mist_core_top.sv
  - target: test
    files:
      - mist_core_assert.sv
      - mist_core_tb.sv
